//--- files.f
+incdir+source
source/vector_pkg.sv
source/fp16_align.sv
source/fp16_addnorm.sv
source/vaddsub.sv
source/result_fifo.sv
source/vector_addsub_top.sv
test/vaddsub_tb.sv

//--- source/fp16_addnorm.sv
module fp16_addnorm (
    input  vector_pkg::align_t lane,      // stage 1 register side
    input  vector_pkg::sum_t   sum,       // stage 2 register side
    output vector_pkg::sum_t   sum_next,  // into the stage 2 register
    output vector_pkg::fp16_t  result     // into the stage 3 register
);

    logic [11:0]       mag;      // raw magnitude of the add half
    logic [3:0]        lz;       // leading zeros in mag[10:0]
    logic [10:0]       norm;     // left normalized significand
    logic [9:0]        frac;     // packed fraction
    logic signed [6:0] exp_ext;  // exponent with room for over and under

    // add half
    always_comb begin
        if (lane.eff_sub) begin
            mag = {1'b0, lane.sig_big} - {1'b0, lane.sig_small};  // big >= small
        end else begin
            mag = {1'b0, lane.sig_big} + {1'b0, lane.sig_small};  // may carry
        end

        if (lane.zero || (mag == 12'd0)) begin
            sum_next.mag  = 12'd0;  // cancellation gives +0
            sum_next.exp  = 5'd0;
            sum_next.sign = 1'b0;
        end else begin
            sum_next.mag  = mag;
            sum_next.exp  = lane.exp;
            sum_next.sign = lane.sign;
        end
    end

    // leading zero count
    always_comb begin
        lz = 4'd0;
        for (int i = 0; i < 11; i++) begin
            if (sum.mag[i]) begin
                lz = 4'(10 - i);  // highest set bit wins
            end
        end
    end

    // normalize half
    always_comb begin
        norm = sum.mag[10:0] << lz;

        if (sum.mag[11]) begin
            exp_ext = $signed({2'b00, sum.exp}) + 7'sd1;  // carry moves point left
            frac    = sum.mag[10:1];                      // lsb is truncated
        end else begin
            exp_ext = $signed({2'b00, sum.exp}) - $signed({3'b000, lz});
            frac    = norm[9:0];
        end

        if ((sum.mag == 12'd0) || (exp_ext < 7'sd1)) begin
            result = {sum.sign, 15'd0};  // signed zero on underflow
        end else if (exp_ext > 7'sd30) begin
            result = {sum.sign, 5'h1f, 10'd0};  // signed infinity
        end else begin
            result = {sum.sign, exp_ext[4:0], frac};
        end
    end

endmodule

//--- source/fp16_align.sv
module fp16_align (
    input  vector_pkg::vop_e   op,
    input  vector_pkg::fp16_t  a,
    input  vector_pkg::fp16_t  b,
    output vector_pkg::align_t lane
);

    logic        sign_b;    // b sign after the opcode
    logic [10:0] sig_a;     // a with hidden one
    logic [10:0] sig_b;     // b with hidden one
    logic        a_big;     // a has the larger magnitude
    logic [4:0]  exp_diff;  // alignment distance
    logic [10:0] sig_lo;    // smaller significand before the shift

    assign sign_b = b.sign ^ (op == vector_pkg::VOP_SUB);  // a - b is a + (-b)

    // exponent 0 is read as zero so denormals vanish here
    assign sig_a = (a.exp == 5'd0) ? 11'd0 : {1'b1, a.frac};
    assign sig_b = (b.exp == 5'd0) ? 11'd0 : {1'b1, b.frac};

    // order by exponent first then by significand
    assign a_big = (a.exp > b.exp) || ((a.exp == b.exp) && (sig_a >= sig_b));

    always_comb begin
        if (a_big) begin
            lane.exp     = a.exp;
            lane.sig_big = sig_a;
            lane.sign    = a.sign;
            sig_lo       = sig_b;
            exp_diff     = a.exp - b.exp;  // never negative here
        end else begin
            lane.exp     = b.exp;
            lane.sig_big = sig_b;
            lane.sign    = sign_b;  // b carries the flipped sign
            sig_lo       = sig_a;
            exp_diff     = b.exp - a.exp;
        end

        // shift drops bits off the right end with no guard or sticky
        if (exp_diff >= 5'd11) begin
            lane.sig_small = 11'd0;  // whole significand shifted out
        end else begin
            lane.sig_small = sig_lo >> exp_diff;
        end

        lane.eff_sub = a.sign ^ sign_b;                     // opposite signs
        lane.zero    = (a.exp == 5'd0) && (b.exp == 5'd0);  // 0 op 0
    end

endmodule

//--- source/result_fifo.sv
`include "vector_config.svh"

module result_fifo (
    input  logic              CLK,
    input  logic              rst,
    input  logic              push,
    input  vector_pkg::vres_t push_data,
    output logic              res_valid,
    output vector_pkg::vres_t res,
    input  logic              res_ready,
    output logic              req_credit
);

    localparam int DEPTH = `VEC_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    vector_pkg::vres_t mem [DEPTH];  // circular buffer
    logic [PTR_W-1:0]  wr_ptr;       // next slot to fill
    logic [PTR_W-1:0]  rd_ptr;       // oldest entry
    logic [CNT_W-1:0]  count;        // entries held
    logic              pop;
    logic              wr_en;

    assign res_valid = (count != '0);          // head is visible as soon as stored
    assign res       = mem[rd_ptr];
    assign pop       = res_valid && res_ready;  // consumer handshake
    assign wr_en     = push && (count != CNT_W'(DEPTH));  // credits keep this true

    always_ff @(posedge CLK) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count + CNT_W'(wr_en) - CNT_W'(pop);
            req_credit <= pop;  // one pulse per freed slot
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- source/vaddsub.sv
`include "vector_config.svh"

// `VEC_PIPE_STAGES register stages, align then add then normalize
module vaddsub (
    input  logic              CLK,
    input  logic              rst,
    input  logic              in_valid,
    input  vector_pkg::vreq_t in_req,
    output logic              out_valid,
    output vector_pkg::vres_t out
);

    vector_pkg::align_vec_t align_c;  // aligned lanes from the request
    vector_pkg::align_vec_t s1_lane;  // stage 1 register
    logic                   s1_valid;

    vector_pkg::sum_vec_t   sum_c;    // raw sums from stage 1
    vector_pkg::sum_vec_t   s2_sum;   // stage 2 register
    logic                   s2_valid;

    vector_pkg::fp16_t [`VEC_LANES-1:0] res_c;  // packed lanes from stage 2

    // one align and one add/normalize slice per lane
    for (genvar l = 0; l < `VEC_LANES; l++) begin : g_lane
        fp16_align u_align (
            .op   (in_req.op),
            .a    (in_req.a[l]),
            .b    (in_req.b[l]),
            .lane (align_c[l])
        );

        // add half reads stage 1, normalize half reads stage 2
        fp16_addnorm u_addnorm (
            .lane     (s1_lane[l]),
            .sum      (s2_sum[l]),
            .sum_next (sum_c[l]),
            .result   (res_c[l])
        );
    end

    // valid chain
    always_ff @(posedge CLK) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;  // push into the result queue
        end
    end

    // payload only moves with its valid bit
    always_ff @(posedge CLK) begin
        if (in_valid) begin
            s1_lane <= align_c;
        end
        if (s1_valid) begin
            s2_sum <= sum_c;
        end
        if (s2_valid) begin
            out.lane <= res_c;
        end
    end

endmodule

//--- source/vector_addsub_top.sv
// fp16 vector add/sub with credit input and valid/ready output
module vector_addsub_top (
    input  logic              CLK,
    input  logic              rst,
    input  logic              req_valid,   // producer holds a credit
    input  vector_pkg::vreq_t req,
    output logic              req_credit,  // one credit back per pulse
    output logic              res_valid,
    output vector_pkg::vres_t res,
    input  logic              res_ready    // consumer back-pressure
);

    logic              pipe_valid;  // pipeline result strobe
    vector_pkg::vres_t pipe_res;    // pipeline result vector

    // three stage datapath, never stalls
    vaddsub u_vaddsub (
        .CLK       (CLK),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_req    (req),
        .out_valid (pipe_valid),
        .out       (pipe_res)
    );

    // results wait here for the consumer
    // queue depth matches the credit pool so a push always finds room
    result_fifo u_result_fifo (
        .CLK        (CLK),
        .rst        (rst),
        .push       (pipe_valid),
        .push_data  (pipe_res),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready),
        .req_credit (req_credit)
    );

endmodule

//--- source/vector_config.svh
`ifndef VECTOR_CONFIG_SVH
`define VECTOR_CONFIG_SVH

// lanes per request vector
`define VEC_LANES 4

// result queue entries
`define VEC_FIFO_DEPTH 4

// producer credits after reset
// one credit per queue slot so the pipeline never has to stall
`define VEC_CREDITS `VEC_FIFO_DEPTH

// register stages in the add/sub pipeline
`define VEC_PIPE_STAGES 3

`endif

//--- source/vector_pkg.sv
`include "vector_config.svh"

package vector_pkg;

    // half precision word
    typedef struct packed {
        logic       sign;  // 1 = negative
        logic [4:0] exp;   // biased exponent, 0 flushes to zero
        logic [9:0] frac;  // fraction without the hidden one
    } fp16_t;

    // vector opcode
    typedef enum logic {
        VOP_ADD = 1'b0,
        VOP_SUB = 1'b1
    } vop_e;

    // request from the producer
    typedef struct packed {
        vop_e                      op;  // same op on every lane
        fp16_t [`VEC_LANES-1:0]    a;   // first operand vector
        fp16_t [`VEC_LANES-1:0]    b;   // second operand vector
    } vreq_t;

    // result vector handed to the consumer
    typedef struct packed {
        fp16_t [`VEC_LANES-1:0] lane;
    } vres_t;

    // stage 1 per lane (after alignment)
    typedef struct packed {
        logic [4:0]  exp;        // larger exponent
        logic [10:0] sig_big;    // larger significand
        logic [10:0] sig_small;  // smaller significand shifted right
        logic        sign;       // sign of larger operand
        logic        eff_sub;    // signs differ so subtract magnitudes
        logic        zero;       // both inputs are zero
    } align_t;

    // stage 2 per lane (raw sum before normalization)
    typedef struct packed {
        logic [11:0] mag;   // bit 11 is the carry out
        logic [4:0]  exp;   // exponent before normalization
        logic        sign;  // result sign
    } sum_t;

    // per stage lane arrays
    typedef align_t [`VEC_LANES-1:0] align_vec_t;
    typedef sum_t   [`VEC_LANES-1:0] sum_vec_t;

endpackage

//--- test/vaddsub_tb.sv
`include "vector_config.svh"

module vaddsub_tb;

    localparam int N_ADD       = 24;  // same-sign add vectors
    localparam int N_SUB       = 32;  // subtract vectors
    localparam int N_EDGE      = 16;  // saturating adds then flushing subtracts
    localparam int HOLD_CYCLES = 12;  // consumer stall in the back-pressure run
    localparam int N_TOTAL     = N_ADD + N_SUB + N_EDGE + 2 * `VEC_CREDITS + 1;
    localparam int LIMIT       = N_TOTAL * (`VEC_PIPE_STAGES + HOLD_CYCLES) + 200;

    logic              CLK;
    logic              rst;
    logic              req_valid;
    vector_pkg::vreq_t req;
    logic              req_credit;
    logic              res_valid;
    vector_pkg::vres_t res;
    logic              res_ready;

    logic [31:0]       lfsr     = 32'h451b_b53e;
    int                spent    = 0;  // requests sent
    int                returned = 0;  // req_credit pulses seen
    int unsigned       cycle    = 0;
    vector_pkg::vres_t exp_q[$];      // expected results in request order
    string             name_q[$];     // test name per expected result

    vector_addsub_top dut (
        .CLK        (CLK),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_value(input string name, input logic [`VEC_LANES*16-1:0] expected,
                                input logic [`VEC_LANES*16-1:0] actual);
        stop_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic int credits_left();
        return `VEC_CREDITS - spent + returned;
    endfunction

    // galois form with the lsb as output bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    // lane model flushes, aligns with truncation, adds, normalizes and clamps
    function automatic vector_pkg::fp16_t ref_lane(input logic sub, input vector_pkg::fp16_t x,
                                                   input vector_pkg::fp16_t y);
        logic sx;
        logic sy;
        logic sgn;
        int   mx;
        int   my;
        int   e;
        int   mag;
        sx = x.sign;
        sy = y.sign ^ sub;                               // a - b as a + (-b)
        mx = (x.exp == 5'd0) ? 0 : 1024 + int'(x.frac);  // exponent 0 reads as zero
        my = (y.exp == 5'd0) ? 0 : 1024 + int'(y.frac);
        if (x.exp > y.exp || (x.exp == y.exp && mx >= my)) begin
            e   = x.exp;
            sgn = sx;
            mag = (sx == sy) ? mx + (my >> (x.exp - y.exp)) : mx - (my >> (x.exp - y.exp));
        end else begin
            e   = y.exp;
            sgn = sy;
            mag = (sx == sy) ? my + (mx >> (y.exp - x.exp)) : my - (mx >> (y.exp - x.exp));
        end
        if (mag == 0) begin
            return 16'h0000;  // cancellation and 0 op 0 give +0
        end
        if (mag >= 2048) begin
            mag = mag >> 1;  // carry out
            e   = e + 1;
        end
        while (mag < 1024) begin
            mag = mag << 1;
            e   = e - 1;
        end
        if (e < 1) begin
            return {sgn, 15'd0};
        end
        if (e > 30) begin
            return {sgn, 5'd31, 10'd0};
        end
        return {sgn, 5'(e), 10'(mag)};  // low bits drop the hidden one
    endfunction

    function automatic vector_pkg::vres_t ref_vec(input vector_pkg::vreq_t r);
        vector_pkg::vres_t v;
        for (int l = 0; l < `VEC_LANES; l++) begin
            v.lane[l] = ref_lane(r.op == vector_pkg::VOP_SUB, r.a[l], r.b[l]);
        end
        return v;
    endfunction

    task automatic random_fp16(input int e_lo, input int e_hi, input logic sign,
                               output vector_pkg::fp16_t v);
        logic [31:0] bits;
        take_bits(5, bits);
        v.exp  = 5'(e_lo + int'(bits[4:0]) % (e_hi - e_lo + 1));  // exponent in range
        take_bits(10, bits);
        v.frac = bits[9:0];
        v.sign = sign;
    endtask

    // both operands of a lane share one sign
    task automatic same_sign_req(input vector_pkg::vop_e op, input int e_lo, input int e_hi,
                                 output vector_pkg::vreq_t r);
        logic [31:0] bits;
        r.op = op;
        for (int l = 0; l < `VEC_LANES; l++) begin
            take_bits(1, bits);
            random_fp16(e_lo, e_hi, bits[0], r.a[l]);
            random_fp16(e_lo, e_hi, bits[0], r.b[l]);
        end
    endtask

    // returns at the edge where the DUT takes the request
    task automatic send_req(input vector_pkg::vreq_t r, input string name);
        while (credits_left() == 0) begin
            req_valid <= 1'b0;  // hold off until a credit returns
            @(posedge CLK);
        end
        req_valid <= 1'b1;
        req       <= r;
        spent++;
        exp_q.push_back(ref_vec(r));
        name_q.push_back(name);
        @(posedge CLK);
    endtask

    task automatic idle();
        req_valid <= 1'b0;
    endtask

    // wait for every result and every credit to come back
    task automatic drain();
        while (exp_q.size() != 0 || credits_left() != `VEC_CREDITS) begin
            @(posedge CLK);
        end
    endtask

    task automatic same_sign_adds();
        vector_pkg::vreq_t r;
        for (int n = 0; n < N_ADD; n++) begin
            same_sign_req(vector_pkg::VOP_ADD, 12, 16, r);  // close exponents give many carries
            send_req(r, "same-sign add");
        end
        idle();
    endtask

    task automatic mixed_subtracts();
        vector_pkg::vreq_t r;
        logic [31:0]       bits;
        logic [31:0]       gap;
        for (int n = 0; n < N_SUB; n++) begin
            r.op = vector_pkg::VOP_SUB;
            for (int l = 0; l < `VEC_LANES; l++) begin
                take_bits(3, bits);  // bit 0 signs a and bits 2:1 pick the lane case
                random_fp16(16, 30, bits[0], r.a[l]);
                case (bits[2:1])
                    2'd0: begin
                        take_bits(5, gap);  // bit 4 sign of b
                        random_fp16(1, 1, gap[4], r.b[l]);
                        r.b[l].exp = r.a[l].exp - 5'(gap[3:0]);  // gap 0 to 15
                    end
                    2'd1: r.b[l] = r.a[l];  // exact cancellation
                    2'd2: begin
                        take_bits(1, gap);
                        random_fp16(0, 0, gap[0], r.b[l]);  // zero b
                    end
                    default: begin
                        take_bits(1, gap);
                        r.a[l].exp = 5'd0;
                        random_fp16(0, 3, gap[0], r.b[l]);  // sometimes both zero
                    end
                endcase
            end
            send_req(r, "subtract");
        end
        idle();
    endtask

    task automatic saturate_and_flush();
        vector_pkg::vreq_t r;
        logic [31:0]       bits;
        for (int n = 0; n < N_EDGE; n++) begin
            if (n < N_EDGE / 2) begin
                same_sign_req(vector_pkg::VOP_ADD, 30, 31, r);
                send_req(r, "saturate");
            end else begin
                r.op = vector_pkg::VOP_SUB;
                for (int l = 0; l < `VEC_LANES; l++) begin
                    take_bits(4, bits);
                    random_fp16(1, 2, bits[0], r.a[l]);
                    r.b[l]           = r.a[l];
                    r.b[l].frac[2:0] = r.a[l].frac[2:0] ^ bits[3:1];  // near cancellation
                end
                send_req(r, "flush");
            end
        end
        idle();
    endtask

    task automatic backpressure_run();
        vector_pkg::vreq_t r;
        int                sent;
        drain();
        res_ready <= 1'b0;  // consumer stalls
        sent = 0;
        while (credits_left() > 0) begin
            same_sign_req(vector_pkg::VOP_SUB, 1, 30, r);
            send_req(r, "back-pressure");
            sent++;
        end
        idle();
        assert (sent == `VEC_CREDITS) else report_value("back-pressure sends", `VEC_CREDITS, sent);
        repeat (HOLD_CYCLES) @(posedge CLK);
        assert (res_valid && credits_left() == 0)
            else stop_run("queue lost its results or returned credits while stalled");
        res_ready <= 1'b1;
        drain();  // results leave in request order
    endtask

    task automatic latency_run();
        vector_pkg::vreq_t r;
        int                edges;
        int                run;
        drain();
        same_sign_req(vector_pkg::VOP_ADD, 1, 30, r);
        send_req(r, "latency");
        idle();
        edges = 0;
        @(negedge CLK);  // between request edge and the next one
        while (!res_valid && edges < 10) begin
            @(negedge CLK);
            edges++;
        end
        assert (edges == `VEC_PIPE_STAGES) else report_value("latency", `VEC_PIPE_STAGES, edges);
        @(posedge CLK);
        drain();
        for (int n = 0; n < `VEC_CREDITS; n++) begin
            same_sign_req(vector_pkg::VOP_SUB, 1, 30, r);
            send_req(r, "back-to-back");
        end
        idle();
        run = 0;
        while (!res_valid) begin
            @(negedge CLK);  // first result of the stream
        end
        while (res_valid) begin
            run++;
            @(negedge CLK);
        end
        assert (run == `VEC_CREDITS) else report_value("back-to-back", `VEC_CREDITS, run);
        @(posedge CLK);
    endtask

    always @(posedge CLK) begin
        if (!rst && req_credit) begin
            returned <= returned + 1;
        end
    end

    always @(posedge CLK) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            stop_run($sformatf("timeout: run did not finish within %0d cycles", LIMIT));
        end
    end

    // values are settled here before the pop edge
    always @(negedge CLK) begin
        if (!rst && res_valid && res_ready) begin
            assert (exp_q.size() > 0) else stop_run("result popped with no request outstanding");
            assert (res == exp_q[0]) else report_value(name_q[0], exp_q[0], res);
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
        end
    end

    credit_range: assert property (@(posedge CLK) disable iff (rst)
        (credits_left() >= 0) && (credits_left() <= `VEC_CREDITS))
        else stop_run("producer credit count went below zero or above the credit pool");

    credit_after_pop: assert property (@(posedge CLK) disable iff (rst)
        (res_valid && res_ready) |=> req_credit)
        else stop_run("no credit pulse in the cycle after a pop");

    no_stray_credit: assert property (@(posedge CLK) disable iff (rst)
        !(res_valid && res_ready) |=> !req_credit)
        else stop_run("credit pulse without a pop");

    hold_stable: assert property (@(posedge CLK) disable iff (rst)
        (res_valid && !res_ready) |=> (res_valid && $stable(res)))
        else stop_run("result changed or vanished while the consumer stalled");

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        res_ready = 1'b1;
        repeat (10) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        assert (!res_valid && !req_credit) else stop_run("res_valid or req_credit high after reset");
        repeat (3) @(posedge CLK);  // idle cycles let any stray credit reach the counter
        @(negedge CLK);
        assert (credits_left() == `VEC_CREDITS)
            else report_value("reset credits", `VEC_CREDITS, credits_left());
        @(posedge CLK);
        same_sign_adds();
        mixed_subtracts();
        saturate_and_flush();
        backpressure_run();
        latency_run();
        drain();
        if (exp_q.size() == 0 && credits_left() == `VEC_CREDITS) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_run("results or credits still outstanding at the end of the run");
        end
    end

endmodule
